// File: fft_pkg.sv
package fft_pkg;

    // words are signed two's complement with frac_w fraction bits
    localparam int data_w = 16;
    localparam int frac_w = 8;

    // a three bit twiddle index allows at most eight twiddle entries
    localparam int tw_idx_w = 3;

    typedef logic signed [data_w-1:0] word_t;

    typedef struct packed {
        word_t re;
        word_t im;
    } cplx_t;

    // one butterfly request carries both samples and the twiddle to use
    typedef struct packed {
        cplx_t                a;
        cplx_t                b;
        logic [tw_idx_w-1:0]  tw_idx;
    } bfly_req_t;

    // sum is a + w*b and diff is a - w*b
    typedef struct packed {
        cplx_t sum;
        cplx_t diff;
    } bfly_res_t;

endpackage

// File: fp_mult.sv
`timescale 1ns/100ps

module fp_mult (
    input  fft_pkg::word_t a,
    input  fft_pkg::word_t b,
    output fft_pkg::word_t c
);

    // both operands are sign extended into the full precision product
    logic signed [2*fft_pkg::data_w-1:0] prod;

    // product realigned to the word's binary point
    logic signed [2*fft_pkg::data_w-1:0] shifted;

    always_comb begin
        prod    = a * b;
        shifted = prod >>> fft_pkg::frac_w;   // arithmetic shift keeps the sign
    end

    // upper bits are simply dropped without saturation
    assign c = shifted[fft_pkg::data_w-1:0];

endmodule

// File: fp_cmult.sv
`timescale 1ns/100ps

module fp_cmult #(
    parameter int num_mults = 1
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           recv_val,
    output logic           recv_rdy,
    input  fft_pkg::cplx_t x,
    input  fft_pkg::cplx_t y,
    output logic           send_val,
    input  logic           send_rdy,
    output fft_pkg::cplx_t z
);

    // z = x * y using three real products
    // re = xr*yr - xi*yi
    // im = (xr + xi)(yr + yi) - xr*yr - xi*yi

    fft_pkg::word_t p_rr;
    fft_pkg::word_t p_ii;
    fft_pkg::word_t p_s;

    generate
        if (num_mults == 3) begin : g_three
            fft_pkg::word_t x_sum;
            fft_pkg::word_t y_sum;

            assign x_sum = x.re + x.im;   // wraps like every other sum
            assign y_sum = y.re + y.im;

            fp_mult m_rr (
                .a(x.re),
                .b(y.re),
                .c(p_rr)
            );

            fp_mult m_ii (
                .a(x.im),
                .b(y.im),
                .c(p_ii)
            );

            fp_mult m_s (
                .a(x_sum),
                .b(y_sum),
                .c(p_s)
            );

            // purely combinational, so the handshake passes straight through
            assign send_val = recv_val;
            assign recv_rdy = send_rdy;
        end else begin : g_one
            localparam logic [2:0] st_idle = 3'd0;
            localparam logic [2:0] st_mul1 = 3'd1;
            localparam logic [2:0] st_mul2 = 3'd2;
            localparam logic [2:0] st_mul3 = 3'd3;
            localparam logic [2:0] st_done = 3'd4;

            logic [2:0]     state;
            logic [2:0]     next_state;
            fft_pkg::cplx_t lx;
            fft_pkg::cplx_t ly;
            fft_pkg::word_t mul_a;
            fft_pkg::word_t mul_b;
            fft_pkg::word_t mul_c;

            always_ff @(posedge clk) begin
                if (reset) begin
                    state <= st_idle;
                end else begin
                    state <= next_state;
                end
            end

            // operands are captured once, then one product lands per state
            always_ff @(posedge clk) begin
                case (state)
                    st_idle: begin
                        if (recv_val) begin
                            lx <= x;
                            ly <= y;
                        end
                    end
                    st_mul1: p_rr <= mul_c;
                    st_mul2: p_ii <= mul_c;
                    st_mul3: p_s  <= mul_c;
                    default: begin
                    end
                endcase
            end

            always_comb begin
                next_state = state;
                recv_rdy   = 1'b0;
                send_val   = 1'b0;
                mul_a      = '0;
                mul_b      = '0;
                case (state)
                    st_idle: begin
                        recv_rdy = 1'b1;
                        if (recv_val) next_state = st_mul1;
                    end
                    st_mul1: begin
                        mul_a      = lx.re;
                        mul_b      = ly.re;
                        next_state = st_mul2;
                    end
                    st_mul2: begin
                        mul_a      = lx.im;
                        mul_b      = ly.im;
                        next_state = st_mul3;
                    end
                    st_mul3: begin
                        mul_a      = lx.re + lx.im;
                        mul_b      = ly.re + ly.im;
                        next_state = st_done;
                    end
                    st_done: begin
                        send_val = 1'b1;   // held until the consumer takes it
                        if (send_rdy) next_state = st_idle;
                    end
                    default: next_state = st_idle;
                endcase
            end

            fp_mult m_shared (
                .a(mul_a),
                .b(mul_b),
                .c(mul_c)
            );
        end
    endgenerate

    always_comb begin
        z.re = p_rr - p_ii;
        z.im = p_s - p_rr - p_ii;
    end

endmodule

// File: twiddle_regs.sv
`timescale 1ns/100ps

module twiddle_regs #(
    parameter int tw_depth = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cfg_we,
    input  logic [fft_pkg::tw_idx_w-1:0] cfg_addr,
    input  fft_pkg::cplx_t               cfg_data,
    input  logic [fft_pkg::tw_idx_w-1:0] tw_idx,
    output fft_pkg::cplx_t               tw
);

    fft_pkg::cplx_t regs [tw_depth];

    logic addr_ok;
    logic idx_ok;

    // the index field may reach past a short table
    assign addr_ok = (cfg_addr < tw_depth);
    assign idx_ok  = (tw_idx < tw_depth);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tw_depth; i++) begin
                regs[i] <= '0;
            end
        end else if (cfg_we && addr_ok) begin
            regs[cfg_addr] <= cfg_data;   // out of range writes are dropped
        end
    end

    // read is combinational and sees the value before a same cycle write
    always_comb begin
        if (idx_ok) begin
            tw = regs[tw_idx];
        end else begin
            tw = '0;
        end
    end

endmodule

// File: butterfly.sv
`timescale 1ns/100ps

module butterfly #(
    parameter int num_mults = 1
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_val,
    output logic                         in_rdy,
    input  fft_pkg::bfly_req_t           in_req,
    output logic [fft_pkg::tw_idx_w-1:0] tw_idx,
    input  fft_pkg::cplx_t               tw,
    output logic                         out_val,
    input  logic                         out_rdy,
    output fft_pkg::bfly_res_t           out_res
);

    logic               cm_recv_rdy;
    logic               cm_send_val;
    logic               cm_send_rdy;
    logic               prod_xfer;
    fft_pkg::cplx_t     prod;
    fft_pkg::cplx_t     a_held;
    fft_pkg::bfly_res_t res_next;

    assign tw_idx = in_req.tw_idx;

    // the output register can take a product if it is empty or draining now
    assign cm_send_rdy = !out_val || out_rdy;
    assign prod_xfer   = cm_send_val && cm_send_rdy;

    // the multiplier decides when a new request may enter
    assign in_rdy = cm_recv_rdy;

    fp_cmult #(
        .num_mults(num_mults)
    ) u_cmult (
        .clk(clk),
        .reset(reset),
        .recv_val(in_val),
        .recv_rdy(cm_recv_rdy),
        .x(in_req.b),
        .y(tw),
        .send_val(cm_send_val),
        .send_rdy(cm_send_rdy),
        .z(prod)
    );

    generate
        if (num_mults == 3) begin : g_pass
            assign a_held = in_req.a;   // product is ready in the same cycle
        end else begin : g_hold
            fft_pkg::cplx_t a_lat;

            // a has to outlive the request while the shared multiplier runs
            always_ff @(posedge clk) begin
                if (in_val && in_rdy) begin
                    a_lat <= in_req.a;
                end
            end

            assign a_held = a_lat;
        end
    endgenerate

    always_comb begin
        res_next.sum.re  = a_held.re + prod.re;
        res_next.sum.im  = a_held.im + prod.im;
        res_next.diff.re = a_held.re - prod.re;
        res_next.diff.im = a_held.im - prod.im;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_val <= 1'b0;
        end else if (prod_xfer) begin
            out_val <= 1'b1;
        end else if (out_rdy) begin
            out_val <= 1'b0;
        end
    end

    // result only changes when a new product is taken, so it holds under stall
    always_ff @(posedge clk) begin
        if (prod_xfer) begin
            out_res <= res_next;
        end
    end

endmodule

// File: butterfly_top.sv
`timescale 1ns/100ps

module butterfly_top #(
    parameter int num_mults = 1,
    parameter int tw_depth  = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_val,
    output logic                         in_rdy,
    input  fft_pkg::bfly_req_t           in_req,
    output logic                         out_val,
    input  logic                         out_rdy,
    output fft_pkg::bfly_res_t           out_res,
    input  logic                         cfg_we,
    input  logic [fft_pkg::tw_idx_w-1:0] cfg_addr,
    input  fft_pkg::cplx_t               cfg_data
);

    logic [fft_pkg::tw_idx_w-1:0] tw_idx;
    fft_pkg::cplx_t               tw;

    twiddle_regs #(
        .tw_depth(tw_depth)
    ) u_twiddle (
        .clk(clk),
        .reset(reset),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data),
        .tw_idx(tw_idx),
        .tw(tw)
    );

    butterfly #(
        .num_mults(num_mults)
    ) u_bfly (
        .clk(clk),
        .reset(reset),
        .in_val(in_val),
        .in_rdy(in_rdy),
        .in_req(in_req),
        .tw_idx(tw_idx),
        .tw(tw),
        .out_val(out_val),
        .out_rdy(out_rdy),
        .out_res(out_res)
    );

endmodule

// File: tb_butterfly.sv
`timescale 1ns/100ps

module tb_butterfly #(
    parameter int num_mults = 1
);

    localparam int tw_depth     = 6;      // short table so addresses 6 and 7 are out of range
    localparam int max_rows     = 32;
    localparam int setup_cycles = 40;
    localparam int exp_latency  = (num_mults == 3) ? 1 : 5;

    logic                         clk;
    logic                         reset;
    logic                         in_val;
    logic                         in_rdy;
    fft_pkg::bfly_req_t           in_req;
    logic                         out_val;
    logic                         out_rdy;
    fft_pkg::bfly_res_t           out_res;
    logic                         cfg_we;
    logic [fft_pkg::tw_idx_w-1:0] cfg_addr;
    fft_pkg::cplx_t               cfg_data;

    // the stimulus table holds one row per butterfly request
    string                        row_name  [max_rows];
    fft_pkg::cplx_t               row_a     [max_rows];
    fft_pkg::cplx_t               row_b     [max_rows];
    int                           row_idx   [max_rows];
    int                           row_stall [max_rows];   // out_rdy low cycles for the result
    fft_pkg::bfly_res_t           exp_res   [max_rows];
    int                           acc_cycle [max_rows];
    int                           n_rows;
    int                           n_phase1;

    fft_pkg::cplx_t               tw_model  [8];
    int                           n_sent;
    int                           n_acc;
    int                           n_out;
    int                           cycle;
    int                           cycle_limit = 1000;
    int                           value_errors;
    int                           protocol_errors;
    bit                           holding;
    bit                           fresh;
    fft_pkg::bfly_res_t           held;
    int                           stall_row;
    int                           stall_left;

    butterfly_top #(
        .num_mults(num_mults),
        .tw_depth(tw_depth)
    ) UUT (
        .clk(clk),
        .reset(reset),
        .in_val(in_val),
        .in_rdy(in_rdy),
        .in_req(in_req),
        .out_val(out_val),
        .out_rdy(out_rdy),
        .out_res(out_res),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data)
    );

    always #50 clk = ~clk;

    function automatic fft_pkg::cplx_t cx(input int re, input int im);
        fft_pkg::cplx_t v;
        v.re = fft_pkg::word_t'(re);
        v.im = fft_pkg::word_t'(im);
        return v;
    endfunction

    // keep the data_w bits of the full signed product just above the fraction
    function automatic fft_pkg::word_t fixed_mul(input fft_pkg::word_t x, input fft_pkg::word_t y);
        logic signed [2*fft_pkg::data_w-1:0] full;
        full = x * y;
        return full[fft_pkg::frac_w +: fft_pkg::data_w];
    endfunction

    function automatic fft_pkg::bfly_res_t butterfly_model(input fft_pkg::cplx_t a,
                                                           input fft_pkg::cplx_t b,
                                                           input fft_pkg::cplx_t w);
        fft_pkg::word_t     k1;
        fft_pkg::word_t     k2;
        fft_pkg::word_t     k3;
        fft_pkg::word_t     bs;
        fft_pkg::word_t     ws;
        fft_pkg::cplx_t     p;
        fft_pkg::bfly_res_t r;
        bs = b.re + b.im;   // operand sums wrap to a word before the product
        ws = w.re + w.im;
        k1 = fixed_mul(b.re, w.re);
        k2 = fixed_mul(b.im, w.im);
        k3 = fixed_mul(bs, ws);
        p.re = k1 - k2;
        p.im = k3 - k1 - k2;
        r.sum.re  = a.re + p.re;
        r.sum.im  = a.im + p.im;
        r.diff.re = a.re - p.re;
        r.diff.im = a.im - p.im;
        return r;
    endfunction

    task automatic add_row(input string name, input fft_pkg::cplx_t a, input fft_pkg::cplx_t b,
                           input int idx, input int stall);
        row_name[n_rows]  = name;
        row_a[n_rows]     = a;
        row_b[n_rows]     = b;
        row_idx[n_rows]   = idx;
        row_stall[n_rows] = stall;
        n_rows++;
    endtask

    task automatic build_table();
        // every twiddle is still zero for these
        add_row("zero_tw_a", cx(100, -200), cx(300, 400), 0, 0);
        add_row("zero_tw_b", cx(-32768, 32767), cx(-1, -1), 5, 0);
        add_row("zero_tw_c", cx(1234, -4321), cx(777, -777), 3, 2);
        add_row("zero_tw_d", fft_pkg::cplx_t'($urandom), fft_pkg::cplx_t'($urandom), 1, 0);
        n_phase1 = n_rows;
        add_row("unit_one", cx(256, 512), cx(-384, 128), 0, 0);
        add_row("minus_j", cx(0, 0), cx(256, -256), 1, 0);
        add_row("unit_neg", cx(-1000, -2000), cx(-300, 700), 0, 3);
        add_row("diag", cx(500, -500), cx(1000, 1000), 4, 0);
        add_row("wrap_sum", cx(32767, 32767), cx(256, 256), 0, 0);
        add_row("wrap_diff", cx(-32768, -32768), cx(256, 256), 0, 1);
        add_row("big_prod", cx(0, 0), cx(32767, -32768), 4, 0);
        add_row("rand_tw2", fft_pkg::cplx_t'($urandom), fft_pkg::cplx_t'($urandom), 2, 0);
        add_row("rand_tw3", fft_pkg::cplx_t'($urandom), fft_pkg::cplx_t'($urandom), 3, 2);
        add_row("rand_tw5", fft_pkg::cplx_t'($urandom), fft_pkg::cplx_t'($urandom), 5, 0);
        add_row("past_depth", cx(-77, 88), cx(4000, -4000), 6, 0);
        for (int i = 0; i < 8; i++) begin
            add_row($sformatf("random_%0d", i), fft_pkg::cplx_t'($urandom),
                    fft_pkg::cplx_t'($urandom), $urandom % 8, $urandom % 4);
        end
    endtask

    task automatic write_twiddle(input int addr, input fft_pkg::cplx_t value);
        cfg_we   = 1'b1;
        cfg_addr = addr[fft_pkg::tw_idx_w-1:0];
        cfg_data = value;
        @(negedge clk);
        cfg_we = 1'b0;
        if (addr < tw_depth) tw_model[addr] = value;
    endtask

    task automatic load_twiddles();
        write_twiddle(0, cx(256, 0));         // 1.0
        write_twiddle(1, cx(0, -256));        // -j
        write_twiddle(2, fft_pkg::cplx_t'($urandom));
        write_twiddle(3, fft_pkg::cplx_t'($urandom));
        write_twiddle(4, cx(181, -181));      // close to exp(-j pi/4)
        write_twiddle(5, fft_pkg::cplx_t'($urandom));
        // these two must be dropped by the register file
        write_twiddle(6, fft_pkg::cplx_t'($urandom));
        write_twiddle(7, cx(256, 256));
    endtask

    // starts and ends on a falling edge
    task automatic send_rows(input int first, input int last);
        for (int k = first; k < last; k++) begin
            in_val        = 1'b1;
            in_req.a      = row_a[k];
            in_req.b      = row_b[k];
            in_req.tw_idx = row_idx[k][fft_pkg::tw_idx_w-1:0];
            exp_res[k]    = butterfly_model(row_a[k], row_b[k], tw_model[row_idx[k]]);
            do @(posedge clk); while (!in_rdy);
            n_sent++;
            @(negedge clk);
        end
        in_val = 1'b0;
    endtask

    task automatic wait_drain();
        while (n_out < n_sent) @(negedge clk);
    endtask

    // out_rdy drops for the row's stall count once its result shows up
    always @(negedge clk) begin
        if (!reset && out_val && n_out < n_rows && stall_row != n_out) begin
            stall_row  = n_out;
            stall_left = row_stall[n_out];
        end
        if (stall_left > 0) begin
            out_rdy = 1'b0;
            stall_left--;
        end else begin
            out_rdy = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d results seen", cycle, n_out, n_rows);
            $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("Testbench failed");
            $finish;
        end else if (!reset) begin
            if (in_val && in_rdy) begin
                acc_cycle[n_acc] = cycle;
                if (num_mults == 3 && n_acc != 0 && n_acc != n_phase1 &&
                    row_stall[n_acc-1] == 0) begin
                    assert (cycle - acc_cycle[n_acc-1] == 1) else begin
                        value_errors++;
                        $display("error: %s accept gap expected 1 actual %0d",
                                 row_name[n_acc], cycle - acc_cycle[n_acc-1]);
                    end
                end
                n_acc++;
            end
            assert (!(holding && !out_val)) else begin
                protocol_errors++;
                $display("out_val dropped while a stalled result was waiting");
            end
            if (out_val && fresh && n_out < n_acc) begin
                // latency only counts when the output was free at acceptance
                if (n_out == 0 || n_out == n_phase1 || row_stall[n_out-1] == 0) begin
                    assert (cycle - acc_cycle[n_out] == exp_latency) else begin
                        value_errors++;
                        $display("error: %s latency expected %0d actual %0d",
                                 row_name[n_out], exp_latency, cycle - acc_cycle[n_out]);
                    end
                end
                fresh = 1'b0;
            end
            if (out_val && holding) begin
                assert (out_res == held) else begin
                    protocol_errors++;
                    $display("error: %s stalled result expected %h actual %h",
                             row_name[n_out], held, out_res);
                end
            end
            if (out_val && !out_rdy) begin
                held    = out_res;
                holding = 1'b1;
            end
            if (out_val && out_rdy) begin
                assert (n_out < n_acc) else begin
                    protocol_errors++;
                    $display("a result came out with no request outstanding");
                end
                if (n_out < n_acc) begin
                    assert (out_res == exp_res[n_out]) else begin
                        value_errors++;
                        $display("error: %s expected %h actual %h",
                                 row_name[n_out], exp_res[n_out], out_res);
                    end
                    n_out++;
                end
                holding = 1'b0;
                fresh   = 1'b1;
            end
        end
    end

    initial begin
        void'($urandom(76));
        clk             = 1'b0;
        reset           = 1'b1;
        in_val          = 1'b0;
        in_req          = '0;
        out_rdy         = 1'b1;
        cfg_we          = 1'b0;
        cfg_addr        = '0;
        cfg_data        = '0;
        n_rows          = 0;
        n_sent          = 0;
        n_acc           = 0;
        n_out           = 0;
        cycle           = 0;
        value_errors    = 0;
        protocol_errors = 0;
        holding         = 1'b0;
        fresh           = 1'b1;
        stall_row       = -1;
        stall_left      = 0;
        for (int i = 0; i < 8; i++) begin
            tw_model[i] = '0;
        end
        build_table();
        cycle_limit = n_rows * 20 + setup_cycles;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (out_val == 1'b0) else begin
            protocol_errors++;
            $display("out_val is high right after reset");
        end

        send_rows(0, n_phase1);
        wait_drain();
        load_twiddles();
        send_rows(n_phase1, n_rows);
        wait_drain();
        repeat (4) @(negedge clk);   // any stray result would show up here

        assert (n_out == n_rows) else begin
            protocol_errors++;
            $display("%0d results seen for %0d requests", n_out, n_rows);
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
fft_pkg.sv
fp_mult.sv
fp_cmult.sv
twiddle_regs.sv
butterfly.sv
butterfly_top.sv
tb_butterfly.sv

// File: Makefile
TOP = tb_butterfly

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with num_mults 1 and 3"
	@echo "  clean  remove build directories and logs"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Gnum_mults=1 -f filelist.f --Mdir obj_m1 -o sim
	./obj_m1/sim > sim_m1.log 2>&1; cat sim_m1.log
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Gnum_mults=3 -f filelist.f --Mdir obj_m3 -o sim
	./obj_m3/sim > sim_m3.log 2>&1; cat sim_m3.log
	! grep -q "Testbench failed" sim_m1.log
	! grep -q "Testbench failed" sim_m3.log
	grep -q "Testbench passed" sim_m1.log
	grep -q "Testbench passed" sim_m3.log

clean:
	rm -rf obj_m1 obj_m3 sim_m1.log sim_m3.log
